// ==== compile.f ====
source/jtag_pkg.sv
source/sync_fifo.sv
source/jtag_tck_gen.sv
source/jtag_shift_engine.sv
source/jtag_bus_regs.sv
source/jtag_bridge_top.sv
tests/tb_clk_gen.sv
tests/tb_jtag_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the JTAG bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_jtag_bridge -f compile.f -o tb_jtag_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_jtag_bridge > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1

// ==== source/jtag_bridge_top.sv ====
`timescale 1ns/1ps

module jtag_bridge_top (
    input  logic                          clk,
    input  logic                          jtag_rstn_sync,
    input  logic                          wr_valid,
    input  jtag_pkg::wr_req_t             wr_req,
    output logic                          wr_ready,
    output logic                          wr_resp_valid,
    output logic [1:0]                    wr_resp,
    input  logic                          wr_resp_ready,
    input  logic                          rd_valid,
    input  logic [jtag_pkg::ADDR_W-1:0]   rd_addr,
    output logic                          rd_ready,
    output logic                          rd_data_valid,
    output jtag_pkg::rd_resp_t            rd_resp,
    input  logic                          rd_data_ready,
    output logic                          tck,
    output logic                          tms,
    output logic                          tdi,
    input  logic                          tdo
);

    logic                        in_push, in_pop, in_clr;
    logic                        cmd_push, cmd_pop, cmd_clr;
    logic                        out_push, out_pop, out_clr;
    logic [jtag_pkg::DATA_W-1:0] in_wr_word, in_rd_word;
    logic [jtag_pkg::DATA_W-1:0] out_wr_word, out_rd_word;
    jtag_pkg::cmd_t              cmd_wr_word, cmd_rd_word;
    jtag_pkg::fifo_flags_t       in_flags, cmd_flags, out_flags;
    jtag_pkg::tck_cfg_t          tck_cfg;
    logic                        run, rise_stb, fall_stb, engine_idle;

    jtag_bus_regs jtag_bus_regs_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .wr_valid(wr_valid), .wr_req(wr_req), .wr_resp_ready(wr_resp_ready),
        .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_data_ready(rd_data_ready),
        .in_flags(in_flags), .cmd_flags(cmd_flags), .out_flags(out_flags),
        .out_word(out_rd_word), .engine_idle(engine_idle),
        .wr_ready(wr_ready), .wr_resp_valid(wr_resp_valid), .wr_resp(wr_resp),
        .rd_ready(rd_ready), .rd_data_valid(rd_data_valid), .rd_resp(rd_resp),
        .in_push(in_push), .in_word(in_wr_word), .cmd_push(cmd_push),
        .cmd_word(cmd_wr_word), .out_pop(out_pop),
        .in_clr(in_clr), .cmd_clr(cmd_clr), .out_clr(out_clr), .tck_cfg(tck_cfg)
    );

    sync_fifo #(.payload_t(logic [jtag_pkg::DATA_W-1:0]), .DEPTH(jtag_pkg::FIFO_DEPTH))
    shift_in_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clr(in_clr),
        .push(in_push), .push_data(in_wr_word), .pop(in_pop),
        .pop_data(in_rd_word), .flags(in_flags)
    );

    sync_fifo #(.payload_t(jtag_pkg::cmd_t), .DEPTH(jtag_pkg::FIFO_DEPTH))
    shift_cmd_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clr(cmd_clr),
        .push(cmd_push), .push_data(cmd_wr_word), .pop(cmd_pop),
        .pop_data(cmd_rd_word), .flags(cmd_flags)
    );

    sync_fifo #(.payload_t(logic [jtag_pkg::DATA_W-1:0]), .DEPTH(jtag_pkg::FIFO_DEPTH))
    shift_out_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clr(out_clr),
        .push(out_push), .push_data(out_wr_word), .pop(out_pop),
        .pop_data(out_rd_word), .flags(out_flags)
    );

    jtag_tck_gen jtag_tck_gen_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .cfg(tck_cfg), .run(run),
        .tck(tck), .rise_stb(rise_stb), .fall_stb(fall_stb)
    );

    jtag_shift_engine jtag_shift_engine_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .rise_stb(rise_stb), .fall_stb(fall_stb), .tdo(tdo),
        .cmd_word(cmd_rd_word), .cmd_flags(cmd_flags),
        .in_word(in_rd_word), .in_flags(in_flags), .out_flags(out_flags),
        .cmd_pop(cmd_pop), .in_pop(in_pop), .out_push(out_push), .out_word(out_wr_word),
        .run(run), .tms(tms), .tdi(tdi), .idle(engine_idle)
    );

endmodule

// ==== source/jtag_bus_regs.sv ====
`timescale 1ns/1ps

module jtag_bus_regs (
    input  logic                          clk,
    input  logic                          jtag_rstn_sync,
    input  logic                          wr_valid,
    input  jtag_pkg::wr_req_t             wr_req,
    input  logic                          wr_resp_ready,
    input  logic                          rd_valid,
    input  logic [jtag_pkg::ADDR_W-1:0]   rd_addr,
    input  logic                          rd_data_ready,
    input  jtag_pkg::fifo_flags_t         in_flags,
    input  jtag_pkg::fifo_flags_t         cmd_flags,
    input  jtag_pkg::fifo_flags_t         out_flags,
    input  logic [jtag_pkg::DATA_W-1:0]   out_word,
    input  logic                          engine_idle,
    output logic                          wr_ready,
    output logic                          wr_resp_valid,
    output logic [1:0]                    wr_resp,
    output logic                          rd_ready,
    output logic                          rd_data_valid,
    output jtag_pkg::rd_resp_t            rd_resp,
    output logic                          in_push,
    output logic [jtag_pkg::DATA_W-1:0]   in_word,
    output logic                          cmd_push,
    output jtag_pkg::cmd_t                cmd_word,
    output logic                          out_pop,
    output logic                          in_clr,
    output logic                          cmd_clr,
    output logic                          out_clr,
    output jtag_pkg::tck_cfg_t            tck_cfg
);

    logic                        wr_fire;
    logic                        wr_err;
    logic                        wr_status;
    logic                        rd_busy;
    logic [jtag_pkg::ADDR_W-1:0] rd_addr_q;
    logic                        rd_is_out;
    logic [jtag_pkg::DATA_W-1:0] status;

    assign wr_ready = !wr_resp_valid
                      && !((wr_req.addr == jtag_pkg::ADDR_SHIFT_IN) && in_flags.full)
                      && !((wr_req.addr == jtag_pkg::ADDR_SHIFT_CMD) && cmd_flags.full);
    assign wr_fire   = wr_valid && wr_ready;
    assign wr_status = wr_fire && (wr_req.addr == jtag_pkg::ADDR_STATUS);
    assign wr_err    = !((wr_req.addr == jtag_pkg::ADDR_STATUS)
                         || (wr_req.addr == jtag_pkg::ADDR_SHIFT_IN)
                         || (wr_req.addr == jtag_pkg::ADDR_SHIFT_CMD)
                         || (wr_req.addr == jtag_pkg::ADDR_SPEED));

    assign in_push  = wr_fire && (wr_req.addr == jtag_pkg::ADDR_SHIFT_IN);
    assign in_word  = wr_req.data;
    assign cmd_push = wr_fire && (wr_req.addr == jtag_pkg::ADDR_SHIFT_CMD);
    assign cmd_word = jtag_pkg::cmd_t'(wr_req.data);

    // write channel, speed register and clear pulses
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_resp_valid       <= 1'b0;
            wr_resp             <= jtag_pkg::RESP_OK;
            in_clr              <= 1'b0;
            cmd_clr             <= 1'b0;
            out_clr             <= 1'b0;
            tck_cfg.high_period <= jtag_pkg::TCK_PERIOD_RESET;
            tck_cfg.low_period  <= jtag_pkg::TCK_PERIOD_RESET;
        end else begin
            if (wr_fire) begin
                wr_resp_valid <= 1'b1;
                wr_resp       <= wr_err ? jtag_pkg::RESP_ERR : jtag_pkg::RESP_OK;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;
            end
            out_clr <= wr_status && wr_req.strb[0] && wr_req.data[jtag_pkg::ST_OUT_CLR];
            in_clr  <= wr_status && wr_req.strb[1] && wr_req.data[jtag_pkg::ST_IN_CLR];
            cmd_clr <= wr_status && wr_req.strb[2] && wr_req.data[jtag_pkg::ST_CMD_CLR];
            if (wr_fire && (wr_req.addr == jtag_pkg::ADDR_SPEED)) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_req.strb[i]) tck_cfg[8*i +: 8] <= wr_req.data[8*i +: 8];
                end
            end
        end
    end

    // clear bits are pulses and always read 0
    always_comb begin
        status                          = '0;
        status[jtag_pkg::ST_OUT_EMPTY]  = out_flags.empty;
        status[jtag_pkg::ST_OUT_FULL]   = out_flags.full;
        status[jtag_pkg::ST_IN_EMPTY]   = in_flags.empty;
        status[jtag_pkg::ST_IN_FULL]    = in_flags.full;
        status[jtag_pkg::ST_CMD_EMPTY]  = cmd_flags.empty;
        status[jtag_pkg::ST_CMD_FULL]   = cmd_flags.full;
        status[jtag_pkg::ST_IDLE]       = engine_idle && cmd_flags.empty;
    end

    assign rd_ready      = !rd_busy;
    assign rd_is_out     = (rd_addr_q == jtag_pkg::ADDR_SHIFT_OUT);
    assign rd_data_valid = rd_busy && !(rd_is_out && out_flags.empty);  // wait for a result
    assign out_pop       = rd_data_valid && rd_data_ready && rd_is_out;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            rd_busy <= 1'b0;
        end else if (rd_valid && rd_ready) begin
            rd_busy <= 1'b1;
        end else if (rd_data_valid && rd_data_ready) begin
            rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) rd_addr_q <= rd_addr;
    end

    always_comb begin
        rd_resp.resp = jtag_pkg::RESP_OK;
        case (rd_addr_q)
            jtag_pkg::ADDR_STATUS:    rd_resp.data = status;
            jtag_pkg::ADDR_SHIFT_OUT: rd_resp.data = out_word;
            jtag_pkg::ADDR_SPEED:     rd_resp.data = tck_cfg;
            default: begin
                rd_resp.data = jtag_pkg::RD_ERR_DATA;  // write-only or unmapped
                rd_resp.resp = jtag_pkg::RESP_ERR;
            end
        endcase
    end

endmodule

// ==== source/jtag_pkg.sv ====
package jtag_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    localparam logic [ADDR_W-1:0] ADDR_STATUS    = 32'd0;
    localparam logic [ADDR_W-1:0] ADDR_SHIFT_OUT = 32'd1; // read only
    localparam logic [ADDR_W-1:0] ADDR_SHIFT_IN  = 32'd2; // write only
    localparam logic [ADDR_W-1:0] ADDR_SHIFT_CMD = 32'd3; // write only
    localparam logic [ADDR_W-1:0] ADDR_SPEED     = 32'd4;

    localparam logic [1:0] RESP_OK  = 2'd0;
    localparam logic [1:0] RESP_ERR = 2'd2;
    localparam logic [DATA_W-1:0] RD_ERR_DATA = '1;
    localparam int FIFO_DEPTH = 8;

    // status register bit positions
    localparam int ST_OUT_CLR   = 0;
    localparam int ST_OUT_EMPTY = 1;
    localparam int ST_OUT_FULL  = 2;
    localparam int ST_IN_CLR    = 8;
    localparam int ST_IN_EMPTY  = 9;
    localparam int ST_IN_FULL   = 10;
    localparam int ST_CMD_CLR   = 16;
    localparam int ST_CMD_EMPTY = 17;
    localparam int ST_CMD_FULL  = 18;
    localparam int ST_IDLE      = 24;

    localparam logic [3:0] CMD_SHIFT = 4'd0;
    localparam logic [3:0] CMD_TMS   = 4'd1;
    localparam int CYCLE_W = 28;
    localparam int TCK_PERIOD_W = 16;
    localparam logic [TCK_PERIOD_W-1:0] TCK_PERIOD_RESET = 16'd1;

    typedef struct packed {
        logic [3:0]         opcode; // bus bits 31:28
        logic [CYCLE_W-1:0] cycles;
    } cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [3:0]        strb;
    } wr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } rd_resp_t;

    typedef struct packed {
        logic [TCK_PERIOD_W-1:0] high_period;
        logic [TCK_PERIOD_W-1:0] low_period;
    } tck_cfg_t;

    typedef struct packed {
        logic empty;
        logic full;
    } fifo_flags_t;

endpackage

// ==== source/jtag_shift_engine.sv ====
`timescale 1ns/1ps

module jtag_shift_engine (
    input  logic                          clk,
    input  logic                          jtag_rstn_sync,
    input  logic                          rise_stb,
    input  logic                          fall_stb,
    input  logic                          tdo,
    input  jtag_pkg::cmd_t                cmd_word,
    input  jtag_pkg::fifo_flags_t         cmd_flags,
    input  logic [jtag_pkg::DATA_W-1:0]   in_word,
    input  jtag_pkg::fifo_flags_t         in_flags,
    input  jtag_pkg::fifo_flags_t         out_flags,
    output logic                          cmd_pop,
    output logic                          in_pop,
    output logic                          out_push,
    output logic [jtag_pkg::DATA_W-1:0]   out_word,
    output logic                          run,
    output logic                          tms,
    output logic                          tdi,
    output logic                          idle
);

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_TMS} state_t;

    state_t                               state;
    logic [jtag_pkg::CYCLE_W-1:0]         remaining;
    logic [$clog2(jtag_pkg::DATA_W)-1:0]  bit_idx;
    logic [jtag_pkg::DATA_W-1:0]          data_reg;
    logic [jtag_pkg::DATA_W-1:0]          capture;
    logic                                 have_word;    // data_reg holds the current word
    logic                                 out_pending;  // capture waits for the result fifo
    logic                                 last_cycle;
    logic                                 word_ok;
    logic                                 stall;

    assign last_cycle = (remaining == 1);
    assign word_ok    = have_word || !in_flags.empty;
    assign stall      = (!have_word && in_flags.empty) || (out_pending && out_flags.full);
    assign run        = ((state == S_SHIFT) && !stall) || (state == S_TMS);
    assign in_pop     = (state == S_SHIFT) && fall_stb && !have_word && !in_flags.empty;
    assign out_push   = out_pending && !out_flags.full;
    assign out_word   = capture;
    assign idle       = (state == S_IDLE) && !out_pending;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state       <= S_IDLE;
            remaining   <= '0;
            bit_idx     <= '0;
            have_word   <= 1'b0;
            out_pending <= 1'b0;
            cmd_pop     <= 1'b0;
            tms         <= 1'b0;
            tdi         <= 1'b0;
        end else begin
            cmd_pop <= 1'b0;
            if (out_push) out_pending <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_pop) begin
                        remaining <= cmd_word.cycles;
                        bit_idx   <= '0;
                        have_word <= 1'b0;
                        if (cmd_word.cycles != '0) begin  // unknown opcodes just drop out
                            if (cmd_word.opcode == jtag_pkg::CMD_SHIFT) state <= S_SHIFT;
                            else if (cmd_word.opcode == jtag_pkg::CMD_TMS) state <= S_TMS;
                        end
                    end else if (!cmd_flags.empty && !out_pending) begin
                        cmd_pop <= 1'b1;
                    end
                end
                S_SHIFT: begin
                    if (fall_stb && word_ok) begin
                        have_word <= 1'b1;
                        tms       <= 1'b0;
                        tdi       <= have_word ? data_reg[bit_idx] : in_word[0];
                    end
                    if (rise_stb) begin
                        bit_idx   <= bit_idx + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (bit_idx == '1) have_word <= 1'b0;   // word used up
                        if (bit_idx == '1 || last_cycle) out_pending <= 1'b1;
                        if (last_cycle) state <= S_IDLE;
                    end
                end
                S_TMS: begin
                    if (fall_stb) begin
                        tms <= 1'b1;
                        tdi <= 1'b0;
                    end
                    if (rise_stb) begin
                        remaining <= remaining - 1'b1;
                        if (last_cycle) state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_pop) data_reg <= in_word;
        if ((state == S_SHIFT) && rise_stb) begin
            if (bit_idx == '0) capture <= {{(jtag_pkg::DATA_W-1){1'b0}}, tdo};  // zero fill
            else capture[bit_idx] <= tdo;
        end
    end

endmodule

// ==== source/jtag_tck_gen.sv ====
`timescale 1ns/1ps

module jtag_tck_gen (
    input  logic               clk,
    input  logic               jtag_rstn_sync,
    input  jtag_pkg::tck_cfg_t cfg,
    input  logic               run,
    output logic               tck,
    output logic               rise_stb,
    output logic               fall_stb
);

    logic [jtag_pkg::TCK_PERIOD_W-1:0] cnt;  // clk cycles left in this phase
    logic                              started;

    // every restart begins with a fall strobe so the engine drives first
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            tck      <= 1'b0;
            cnt      <= '0;
            started  <= 1'b0;
            rise_stb <= 1'b0;
            fall_stb <= 1'b0;
        end else begin
            rise_stb <= 1'b0;
            fall_stb <= 1'b0;
            if (!run) begin
                tck     <= 1'b0;  // park low while stalled
                cnt     <= '0;
                started <= 1'b0;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (tck || !started) begin
                tck      <= 1'b0;
                fall_stb <= 1'b1;
                started  <= 1'b1;
                cnt      <= cfg.low_period - 1'b1;
            end else begin
                tck      <= 1'b1;
                rise_stb <= 1'b1;
                cnt      <= cfg.high_period - 1'b1;
            end
        end
    end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic                  clk,
    input  logic                  jtag_rstn_sync,
    input  logic                  clr,
    input  logic                  push,
    input  payload_t              push_data,
    input  logic                  pop,
    output payload_t              pop_data,
    output jtag_pkg::fifo_flags_t flags
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign flags.empty = (count == 0);
    assign flags.full  = (count == DEPTH);
    assign do_push     = push && !flags.full;   // push into a full fifo is dropped
    assign do_pop      = pop && !flags.empty;
    assign pop_data    = mem[rd_ptr];           // head word visible without a pop

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (!do_push && do_pop) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !clr) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

endmodule

// ==== tests/tb_jtag_bridge.sv ====
`timescale 1ns/1ps

module tb_jtag_bridge;

    localparam int TIMEOUT = 2000;  // clk cycles per handshake wait
    localparam int MAX_POLLS = 500;

    logic               clk;
    logic               jtag_rstn_sync;
    logic               wr_valid;
    jtag_pkg::wr_req_t  wr_req;
    logic               wr_ready;
    logic               wr_resp_valid;
    logic [1:0]         wr_resp;
    logic               wr_resp_ready;
    logic               rd_valid;
    logic [31:0]        rd_addr;
    logic               rd_ready;
    logic               rd_data_valid;
    jtag_pkg::rd_resp_t rd_resp;
    logic               rd_data_ready;
    logic               tck;
    logic               tms;
    logic               tdi;
    logic               tdo;

    integer      seed = 32'he6d;
    int          error_count;
    int          test_errors;     // error count when the current test began
    int unsigned tck_rises = 0;
    int unsigned tms_rises = 0;
    logic        tck_q = 1'b0;

    tb_clk_gen tb_clk_gen_inst (.clk(clk));

    jtag_bridge_top jtag_bridge_top_inst (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync),
        .wr_valid(wr_valid), .wr_req(wr_req), .wr_ready(wr_ready),
        .wr_resp_valid(wr_resp_valid), .wr_resp(wr_resp), .wr_resp_ready(wr_resp_ready),
        .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready),
        .rd_data_valid(rd_data_valid), .rd_resp(rd_resp), .rd_data_ready(rd_data_ready),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo)
    );

    assign tdo = tdi;  // loopback, captured bits mirror shifted bits

    // tms can move on the same clk edge that raises tck, so look one clk later
    always @(posedge clk) begin
        tck_q <= tck;
        if (tck && !tck_q) begin
            tck_rises <= tck_rises + 1;
            if (tms) tms_rises <= tms_rises + 1;
        end
    end

    // idle engine with all three fifos empty
    function automatic logic [31:0] idle_status();
        logic [31:0] word;
        word                         = '0;
        word[jtag_pkg::ST_IDLE]      = 1'b1;
        word[jtag_pkg::ST_CMD_EMPTY] = 1'b1;
        word[jtag_pkg::ST_IN_EMPTY]  = 1'b1;
        word[jtag_pkg::ST_OUT_EMPTY] = 1'b1;
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int waited;
        resp        = 2'bxx;
        wr_valid    <= 1'b1;
        wr_req.addr <= addr;
        wr_req.data <= data;
        wr_req.strb <= strb;
        waited      = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!(wr_valid && wr_ready) && waited < TIMEOUT);
        wr_valid <= 1'b0;
        if (!wr_ready) begin
            $display("write to address 0x%08h was never accepted", addr);
            error_count++;
        end else begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!(wr_resp_valid && wr_resp_ready) && waited < TIMEOUT);
            if (wr_resp_valid) begin
                resp = wr_resp;
            end else begin
                $display("write to address 0x%08h never got a response", addr);
                error_count++;
            end
        end
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        data     = 'x;
        resp     = 2'bxx;
        rd_valid <= 1'b1;
        rd_addr  <= addr;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!(rd_valid && rd_ready) && waited < TIMEOUT);
        rd_valid <= 1'b0;
        if (!rd_ready) begin
            $display("read of address 0x%08h was never accepted", addr);
            error_count++;
        end else begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!(rd_data_valid && rd_data_ready) && waited < TIMEOUT);
            if (rd_data_valid) begin
                data = rd_resp.data;
                resp = rd_resp.resp;
            end else begin
                $display("read of address 0x%08h never returned data", addr);
                error_count++;
            end
        end
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        do begin
            read_word(jtag_pkg::ADDR_STATUS, status, resp);
            polls++;
        end while (status[jtag_pkg::ST_IDLE] !== 1'b1 && polls < MAX_POLLS);
        if (status[jtag_pkg::ST_IDLE] !== 1'b1) begin
            $display("engine did not return to idle after %0d status reads", polls);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] sent [4];
        logic [1:0]  resp;
        int unsigned rises_start;
        int unsigned tms_start;

        jtag_rstn_sync = 1'b0;
        wr_valid       = 1'b0;
        wr_req         = '0;
        wr_resp_ready  = 1'b1;
        rd_valid       = 1'b0;
        rd_addr        = '0;
        rd_data_ready  = 1'b1;
        error_count    = 0;
        test_errors    = 0;
        repeat (16) @(posedge clk);
        jtag_rstn_sync <= 1'b1;
        @(posedge clk);

        read_word(jtag_pkg::ADDR_STATUS, data, resp);
        check_value("rd_resp.data", data, idle_status());
        check_value("rd_resp.resp", 32'(resp), 32'(jtag_pkg::RESP_OK));
        read_word(jtag_pkg::ADDR_SPEED, data, resp);
        check_value("rd_resp.data", data, 32'h0001_0001);
        report_test(1, "state after reset");

        write_word(jtag_pkg::ADDR_SHIFT_OUT, 32'h1234_5678, 4'hf, resp);
        check_value("wr_resp", 32'(resp), 32'(jtag_pkg::RESP_ERR));
        write_word(32'd9, 32'h1234_5678, 4'hf, resp);
        check_value("wr_resp", 32'(resp), 32'(jtag_pkg::RESP_ERR));
        read_word(jtag_pkg::ADDR_SHIFT_IN, data, resp);
        check_value("rd_resp.data", data, 32'hffff_ffff);
        check_value("rd_resp.resp", 32'(resp), 32'(jtag_pkg::RESP_ERR));
        read_word(32'd9, data, resp);
        check_value("rd_resp.data", data, 32'hffff_ffff);
        check_value("rd_resp.resp", 32'(resp), 32'(jtag_pkg::RESP_ERR));
        read_word(jtag_pkg::ADDR_STATUS, data, resp);
        check_value("rd_resp.data", data, idle_status());  // errors left no trace
        report_test(2, "error responses");

        write_word(jtag_pkg::ADDR_SPEED, 32'h0003_0002, 4'hf, resp);
        read_word(jtag_pkg::ADDR_SPEED, data, resp);
        check_value("rd_resp.data", data, 32'h0003_0002);
        write_word(jtag_pkg::ADDR_SPEED, 32'ha5ff_ffff, 4'b1000, resp);
        read_word(jtag_pkg::ADDR_SPEED, data, resp);
        check_value("rd_resp.data", data, 32'ha503_0002);  // only the top byte moved
        write_word(jtag_pkg::ADDR_SPEED, 32'h0001_0001, 4'hf, resp);  // back to fast tck
        report_test(3, "speed register byte strobes");

        for (int i = 0; i < 4; i++) begin
            sent[i] = $random(seed);
            write_word(jtag_pkg::ADDR_SHIFT_IN, sent[i], 4'hf, resp);
            check_value("wr_resp", 32'(resp), 32'(jtag_pkg::RESP_OK));
        end
        rises_start = tck_rises;
        write_word(jtag_pkg::ADDR_SHIFT_CMD, {jtag_pkg::CMD_SHIFT, 28'd128}, 4'hf, resp);
        wait_idle();
        check_value("tck rising edges", tck_rises - rises_start, 32'd128);
        for (int i = 0; i < 4; i++) begin
            read_word(jtag_pkg::ADDR_SHIFT_OUT, data, resp);
            check_value("rd_resp.data", data, sent[i]);
            check_value("rd_resp.resp", 32'(resp), 32'(jtag_pkg::RESP_OK));
        end
        report_test(4, "loopback shift");

        rises_start = tck_rises;
        tms_start   = tms_rises;
        write_word(jtag_pkg::ADDR_SHIFT_CMD, {jtag_pkg::CMD_TMS, 28'd5}, 4'hf, resp);
        wait_idle();
        check_value("tck rising edges", tck_rises - rises_start, 32'd5);
        check_value("tms high at tck rise", tms_rises - tms_start, 32'd5);
        read_word(jtag_pkg::ADDR_STATUS, data, resp);
        check_value("rd_resp.data", data, idle_status());  // result fifo still empty
        report_test(5, "tms run");

        write_word(jtag_pkg::ADDR_SHIFT_IN, 32'hdead_beef, 4'hf, resp);
        write_word(jtag_pkg::ADDR_SHIFT_IN, 32'h0bad_f00d, 4'hf, resp);
        read_word(jtag_pkg::ADDR_STATUS, data, resp);
        check_value("status in_empty", 32'(data[jtag_pkg::ST_IN_EMPTY]), 32'd0);
        write_word(jtag_pkg::ADDR_STATUS, 32'h0000_0100, 4'b0010, resp);
        read_word(jtag_pkg::ADDR_STATUS, data, resp);
        check_value("rd_resp.data", data, idle_status());  // empty again, clear reads 0
        report_test(6, "fifo clear");

        $display("tests: 6, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
